// File: sources.f
hw/btac_cfg_pkg.sv
hw/btac_pred_pkg.sv
hw/btb_ram.sv
hw/bht_ram.sv
hw/btac_resolve.sv
hw/btac_ctrl.sv
hw/btac.sv
dv/btac_tb.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP       := btac_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, so the simulator's own exit status is ignored here.
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/btac_tb.sv
`timescale 1ns/1ps
`default_nettype none

module btac_tb;

  localparam int clock_period = 20;
  localparam int reset_cycles = 16;
  localparam int test_cycles = 9 + 9 + 1 + 7 + 5 + 5; // one entry per test, in run order.
  localparam int margin_cycles = 40;

  logic                          clock = 1'b0;
  logic                          reset;
  logic                          clear;
  logic                          stall;
  logic [31:0]                   fetch_pc0;
  logic [31:0]                   fetch_pc1;
  logic                          pred_taken0;
  logic                          pred_taken1;
  logic [31:0]                   pred_target0;
  logic [31:0]                   pred_target1;
  btac_pred_pkg::counter_state_t pred_counter0;
  btac_pred_pkg::counter_state_t pred_counter1;
  logic [31:0]                   upd_pc0;
  logic [31:0]                   upd_npc0;
  logic [31:0]                   upd_addr0;
  btac_pred_pkg::outcome_t       upd_outcome0;
  logic                          upd_pred_taken0;
  logic [31:0]                   upd_pred_target0;
  btac_pred_pkg::counter_state_t upd_pred_counter0;
  logic [31:0]                   upd_pc1;
  logic [31:0]                   upd_npc1;
  logic [31:0]                   upd_addr1;
  btac_pred_pkg::outcome_t       upd_outcome1;
  logic                          upd_pred_taken1;
  logic [31:0]                   upd_pred_target1;
  btac_pred_pkg::counter_state_t upd_pred_counter1;
  logic                          redirect_miss;
  logic [31:0]                   redirect_addr;
  logic                          redirect_hazard;

  int          seed = 32'h36cd_cc3c;
  logic [31:0] jump_pc;
  logic [31:0] jump_target;

  // reference copy of both tables.
  logic [btac_cfg_pkg::btb_tag_bits-1:0] model_tag [btac_cfg_pkg::btb_entries];
  logic [31:0]                           model_target [btac_cfg_pkg::btb_entries];
  btac_pred_pkg::counter_state_t         model_count [btac_cfg_pkg::bht_entries];

  btac UUT (.*);

  always #(clock_period / 2) clock = ~clock;

  initial begin
    #((reset_cycles + 1 + test_cycles + margin_cycles) * clock_period);
    $display("timeout: the directed tests did not complete in time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] random_pc();
    return $random(seed) & 32'hffff_fffe; // halfword aligned.
  endfunction

  function automatic int btb_index(input logic [31:0] pc);
    return int'(pc[6:1]);
  endfunction

  function automatic int bht_index(input logic [31:0] pc);
    return int'(pc[8:1]);
  endfunction

  function automatic logic model_taken(input logic [31:0] pc);
    return model_count[bht_index(pc)][1] && (model_tag[btb_index(pc)] == pc[31:7]);
  endfunction

  task automatic model_resolve(
    input  btac_pred_pkg::outcome_t       outcome,
    input  logic                          pred_taken,
    input  logic [31:0]                   pred_target,
    input  logic [31:0]                   npc,
    input  logic [31:0]                   addr,
    input  btac_pred_pkg::counter_state_t counter,
    output btac_pred_pkg::resolve_kind_t  kind,
    output logic [31:0]                   fix,
    output logic [31:0]                   store,
    output btac_pred_pkg::counter_state_t next
  );
    logic taken;
    taken = (outcome == btac_pred_pkg::outcome_taken) || (outcome == btac_pred_pkg::outcome_jump);
    kind = btac_pred_pkg::resolve_idle;
    fix = '0;
    store = '0;
    if (pred_taken && taken) begin
      kind = (addr == pred_target) ? btac_pred_pkg::resolve_hit : btac_pred_pkg::resolve_miss;
      fix = addr;
      store = addr;
    end else if (pred_taken) begin
      kind = btac_pred_pkg::resolve_miss;
      fix = npc;
      store = (outcome == btac_pred_pkg::outcome_not_taken) ? addr : npc;
    end else if (taken) begin
      kind = btac_pred_pkg::resolve_miss;
      fix = addr;
      store = addr;
    end
    if (taken) begin
      next = (counter == btac_pred_pkg::strong_taken) ? counter :
             btac_pred_pkg::counter_state_t'(counter + 2'd1);
    end else begin
      next = (counter == btac_pred_pkg::strong_not_taken) ? counter :
             btac_pred_pkg::counter_state_t'(counter - 2'd1);
    end
  endtask

  task automatic idle_slots();
    upd_pc0 = '0;
    upd_npc0 = '0;
    upd_addr0 = '0;
    upd_outcome0 = btac_pred_pkg::outcome_none;
    upd_pred_taken0 = 1'b0;
    upd_pred_target0 = '0;
    upd_pred_counter0 = btac_pred_pkg::strong_not_taken;
    upd_pc1 = '0;
    upd_npc1 = '0;
    upd_addr1 = '0;
    upd_outcome1 = btac_pred_pkg::outcome_none;
    upd_pred_taken1 = 1'b0;
    upd_pred_target1 = '0;
    upd_pred_counter1 = btac_pred_pkg::strong_not_taken;
  endtask

  // the prediction fields are what a lookup of pc returned.
  task automatic set_slot(input int slot, input logic [31:0] pc,
                          input btac_pred_pkg::outcome_t outcome, input logic [31:0] addr);
    if (slot == 0) begin
      upd_pc0 = pc;
      upd_npc0 = pc + 32'd4;
      upd_addr0 = addr;
      upd_outcome0 = outcome;
      upd_pred_taken0 = model_taken(pc);
      upd_pred_target0 = model_target[btb_index(pc)];
      upd_pred_counter0 = model_count[bht_index(pc)];
    end else begin
      upd_pc1 = pc;
      upd_npc1 = pc + 32'd4;
      upd_addr1 = addr;
      upd_outcome1 = outcome;
      upd_pred_taken1 = model_taken(pc);
      upd_pred_target1 = model_target[btb_index(pc)];
      upd_pred_counter1 = model_count[bht_index(pc)];
    end
  endtask

  task automatic write_model(input logic [31:0] pc, input logic [31:0] store,
                             input btac_pred_pkg::counter_state_t next);
    model_tag[btb_index(pc)] = pc[31:7];
    model_target[btb_index(pc)] = store;
    model_count[bht_index(pc)] = next;
  endtask

  // called at a falling edge with the slots already driven.
  task automatic resolve_cycle();
    btac_pred_pkg::resolve_kind_t  kind0;
    btac_pred_pkg::resolve_kind_t  kind1;
    logic [31:0]                   fix0;
    logic [31:0]                   fix1;
    logic [31:0]                   store0;
    logic [31:0]                   store1;
    btac_pred_pkg::counter_state_t next0;
    btac_pred_pkg::counter_state_t next1;
    logic                          blocked;
    logic                          miss0;
    logic                          miss1;
    model_resolve(upd_outcome0, upd_pred_taken0, upd_pred_target0, upd_npc0, upd_addr0,
                  upd_pred_counter0, kind0, fix0, store0, next0);
    model_resolve(upd_outcome1, upd_pred_taken1, upd_pred_target1, upd_npc1, upd_addr1,
                  upd_pred_counter1, kind1, fix1, store1, next1);
    blocked = clear;
    miss0 = !blocked && (kind0 == btac_pred_pkg::resolve_miss);
    miss1 = !blocked && (kind1 == btac_pred_pkg::resolve_miss);
    #1;
    check_value("redirect_hazard", 64'(redirect_hazard), 64'(miss0));
    @(negedge clock);
    if (!blocked && kind0 != btac_pred_pkg::resolve_idle) begin
      write_model(upd_pc0, store0, next0);
    end else if (!blocked && kind1 != btac_pred_pkg::resolve_idle) begin
      write_model(upd_pc1, store1, next1);
    end
    check_value("redirect_miss", 64'(redirect_miss), 64'(miss0 || miss1));
    if (miss0 || miss1) begin
      check_value("redirect_addr", 64'(redirect_addr), 64'(miss0 ? fix0 : fix1));
    end
    idle_slots();
  endtask

  task automatic lookup(input logic [31:0] pc0, input logic [31:0] pc1);
    logic live;
    fetch_pc0 = pc0;
    fetch_pc1 = pc1;
    @(negedge clock);
    live = !stall && !clear;
    check_value("pred_taken0", 64'(pred_taken0), 64'(live && model_taken(pc0)));
    check_value("pred_target0", 64'(pred_target0),
                live ? 64'(model_target[btb_index(pc0)]) : 64'h0);
    check_value("pred_counter0", 64'(pred_counter0),
                live ? 64'(model_count[bht_index(pc0)]) : 64'h0);
    check_value("pred_taken1", 64'(pred_taken1), 64'(live && model_taken(pc1)));
    check_value("pred_target1", 64'(pred_target1),
                live ? 64'(model_target[btb_index(pc1)]) : 64'h0);
    check_value("pred_counter1", 64'(pred_counter1),
                live ? 64'(model_count[bht_index(pc1)]) : 64'h0);
  endtask

  // entered at the falling edge before the last reset edge.
  task automatic reset_test();
    logic [31:0]                   miss_pc;
    logic [31:0]                   miss_target;
    btac_pred_pkg::resolve_kind_t  kind;
    logic [31:0]                   fix;
    logic [31:0]                   store;
    btac_pred_pkg::counter_state_t next_count;
    miss_pc = random_pc();
    miss_target = random_pc();
    set_slot(0, miss_pc, btac_pred_pkg::outcome_jump, miss_target); // a miss at the reset edge.
    model_resolve(upd_outcome0, upd_pred_taken0, upd_pred_target0, upd_npc0, upd_addr0,
                  upd_pred_counter0, kind, fix, store, next_count);
    @(negedge clock);
    if (kind != btac_pred_pkg::resolve_idle) begin
      write_model(miss_pc, store, next_count);
    end
    idle_slots();
    reset = 1'b1;
    check_value("redirect_miss", 64'(redirect_miss), 64'h0);
    repeat (8) lookup(random_pc(), random_pc()); // empty tables predict not taken.
  endtask

  task automatic training_test();
    btac_pred_pkg::counter_state_t steps [4];
    steps[0] = btac_pred_pkg::weak_not_taken;
    steps[1] = btac_pred_pkg::weak_taken;
    steps[2] = btac_pred_pkg::strong_taken;
    steps[3] = btac_pred_pkg::strong_taken;
    jump_pc = random_pc();
    jump_target = random_pc();
    lookup(jump_pc, jump_pc + 32'd2);
    for (int i = 0; i < 4; i++) begin
      set_slot(0, jump_pc, btac_pred_pkg::outcome_jump, jump_target);
      resolve_cycle();
      if (i == 0) begin
        check_value("redirect_addr", 64'(redirect_addr), 64'(jump_target));
      end
      lookup(jump_pc, jump_pc + 32'd2);
      check_value("pred_counter0", 64'(pred_counter0), 64'(steps[i]));
    end
    check_value("pred_taken0", 64'(pred_taken0), 64'h1);
    check_value("pred_target0", 64'(pred_target0), 64'(jump_target));
  endtask

  task automatic alias_test();
    logic [31:0] alias_pc;
    alias_pc = jump_pc ^ 32'h0000_0400; // same indices, other tag.
    lookup(alias_pc, jump_pc);
    check_value("pred_taken0", 64'(pred_taken0), 64'h0);
    check_value("pred_target0", 64'(pred_target0), 64'(jump_target));
  endtask

  task automatic mispredict_test();
    logic [31:0] new_target;
    new_target = random_pc();
    set_slot(0, jump_pc, btac_pred_pkg::outcome_taken, new_target);
    resolve_cycle();
    check_value("redirect_addr", 64'(redirect_addr), 64'(new_target));
    lookup(jump_pc, new_target);
    set_slot(0, jump_pc, btac_pred_pkg::outcome_not_taken, jump_target);
    resolve_cycle();
    check_value("redirect_addr", 64'(redirect_addr), 64'(jump_pc + 32'd4));
    lookup(jump_pc, new_target);
    check_value("pred_counter0", 64'(pred_counter0), 64'(btac_pred_pkg::weak_taken));
    set_slot(0, jump_pc, btac_pred_pkg::outcome_taken, jump_target);
    resolve_cycle();
    check_value("redirect_miss", 64'(redirect_miss), 64'h0);
    lookup(jump_pc, new_target);
  endtask

  task automatic priority_test();
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    logic [31:0] target_a;
    logic [31:0] target_b;
    pc_a = random_pc();
    pc_b = pc_a ^ 32'h0000_0002;
    target_a = random_pc();
    target_b = random_pc();
    set_slot(0, pc_a, btac_pred_pkg::outcome_jump, target_a);
    set_slot(1, pc_b, btac_pred_pkg::outcome_jump, target_b);
    resolve_cycle();
    check_value("redirect_addr", 64'(redirect_addr), 64'(target_a));
    lookup(pc_a, pc_b);
    check_value("pred_target0", 64'(pred_target0), 64'(target_a));
    set_slot(1, pc_b, btac_pred_pkg::outcome_jump, target_b);
    resolve_cycle();
    check_value("redirect_addr", 64'(redirect_addr), 64'(target_b));
    lookup(pc_a, pc_b);
    check_value("pred_target1", 64'(pred_target1), 64'(target_b));
  endtask

  task automatic clear_stall_test();
    logic [31:0] other_pc;
    other_pc = random_pc();
    stall = 1'b1;
    lookup(jump_pc, other_pc);
    stall = 1'b0;
    clear = 1'b1;
    lookup(jump_pc, other_pc);
    set_slot(0, jump_pc, btac_pred_pkg::outcome_not_taken, random_pc());
    set_slot(1, other_pc, btac_pred_pkg::outcome_jump, random_pc());
    resolve_cycle(); // the model sees clear and leaves both tables alone.
    clear = 1'b0;
    lookup(jump_pc, other_pc);
    check_value("pred_taken0", 64'(pred_taken0), 64'h1);
  endtask

  initial begin
    for (int i = 0; i < btac_cfg_pkg::btb_entries; i++) begin
      model_tag[i] = '0;
      model_target[i] = '0;
    end
    for (int i = 0; i < btac_cfg_pkg::bht_entries; i++) begin
      model_count[i] = btac_pred_pkg::strong_not_taken;
    end
    reset = 1'b0;
    clear = 1'b0;
    stall = 1'b0;
    fetch_pc0 = '0;
    fetch_pc1 = '0;
    idle_slots();
    repeat (reset_cycles - 1) @(negedge clock);
    reset_test();
    training_test();
    alias_test();
    mispredict_test();
    priority_test();
    clear_stall_test();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/btac.sv
`timescale 1ns/1ps
`default_nettype none

module btac (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 clear,
  input  wire                                 stall,
  input  wire  [31:0]                         fetch_pc0,
  input  wire  [31:0]                         fetch_pc1,
  output logic                                pred_taken0,
  output logic                                pred_taken1,
  output logic [31:0]                         pred_target0,
  output logic [31:0]                         pred_target1,
  output btac_pred_pkg::counter_state_t       pred_counter0,
  output btac_pred_pkg::counter_state_t       pred_counter1,
  input  wire  [31:0]                         upd_pc0,
  input  wire  [31:0]                         upd_npc0,
  input  wire  [31:0]                         upd_addr0,
  input  wire  btac_pred_pkg::outcome_t       upd_outcome0,
  input  wire                                 upd_pred_taken0,
  input  wire  [31:0]                         upd_pred_target0,
  input  wire  btac_pred_pkg::counter_state_t upd_pred_counter0,
  input  wire  [31:0]                         upd_pc1,
  input  wire  [31:0]                         upd_npc1,
  input  wire  [31:0]                         upd_addr1,
  input  wire  btac_pred_pkg::outcome_t       upd_outcome1,
  input  wire                                 upd_pred_taken1,
  input  wire  [31:0]                         upd_pred_target1,
  input  wire  btac_pred_pkg::counter_state_t upd_pred_counter1,
  output logic                                redirect_miss,
  output logic [31:0]                         redirect_addr,
  output logic                                redirect_hazard
);

  logic                                    btb_wen;
  logic [btac_cfg_pkg::btb_index_bits-1:0] btb_waddr;
  logic [btac_cfg_pkg::btb_data_bits-1:0]  btb_wdata;
  logic [btac_cfg_pkg::btb_index_bits-1:0] btb_raddr0;
  logic [btac_cfg_pkg::btb_index_bits-1:0] btb_raddr1;
  logic [btac_cfg_pkg::btb_data_bits-1:0]  btb_rdata0;
  logic [btac_cfg_pkg::btb_data_bits-1:0]  btb_rdata1;
  logic                                    bht_wen;
  logic [btac_cfg_pkg::bht_index_bits-1:0] bht_waddr;
  btac_pred_pkg::counter_state_t           bht_wdata;
  logic [btac_cfg_pkg::bht_index_bits-1:0] bht_raddr0;
  logic [btac_cfg_pkg::bht_index_bits-1:0] bht_raddr1;
  btac_pred_pkg::counter_state_t           bht_rdata0;
  btac_pred_pkg::counter_state_t           bht_rdata1;
  btac_pred_pkg::resolve_kind_t            kind0;
  btac_pred_pkg::resolve_kind_t            kind1;
  logic [31:0]                             fix_addr0;
  logic [31:0]                             fix_addr1;
  logic [31:0]                             store_target0;
  logic [31:0]                             store_target1;
  btac_pred_pkg::counter_state_t           next_counter0;
  btac_pred_pkg::counter_state_t           next_counter1;

  btac_ctrl ctrl (.*);

  btac_resolve resolve (.*); // port names match the update inputs and result wires.

  btb_ram btb (
    .clock  (clock),
    .wen    (btb_wen),
    .waddr  (btb_waddr),
    .wdata  (btb_wdata),
    .raddr0 (btb_raddr0),
    .raddr1 (btb_raddr1),
    .rdata0 (btb_rdata0),
    .rdata1 (btb_rdata1)
  );

  bht_ram bht (
    .clock  (clock),
    .wen    (bht_wen),
    .waddr  (bht_waddr),
    .wdata  (bht_wdata),
    .raddr0 (bht_raddr0),
    .raddr1 (bht_raddr1),
    .rdata0 (bht_rdata0),
    .rdata1 (bht_rdata1)
  );

endmodule

`default_nettype wire

// File: hw/btac_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module btac_ctrl (
  input  wire                                     clock,
  input  wire                                     reset,
  input  wire                                     clear,
  input  wire                                     stall,
  input  wire  [31:0]                             fetch_pc0,
  input  wire  [31:0]                             fetch_pc1,
  output logic                                    pred_taken0,
  output logic                                    pred_taken1,
  output logic [31:0]                             pred_target0,
  output logic [31:0]                             pred_target1,
  output btac_pred_pkg::counter_state_t           pred_counter0,
  output btac_pred_pkg::counter_state_t           pred_counter1,
  input  wire  [31:0]                             upd_pc0,
  input  wire  [31:0]                             upd_pc1,
  output logic                                    redirect_miss,
  output logic [31:0]                             redirect_addr,
  output logic                                    redirect_hazard,
  output logic                                    btb_wen,
  output logic [btac_cfg_pkg::btb_index_bits-1:0] btb_waddr,
  output logic [btac_cfg_pkg::btb_data_bits-1:0]  btb_wdata,
  output logic [btac_cfg_pkg::btb_index_bits-1:0] btb_raddr0,
  output logic [btac_cfg_pkg::btb_index_bits-1:0] btb_raddr1,
  input  wire  [btac_cfg_pkg::btb_data_bits-1:0]  btb_rdata0,
  input  wire  [btac_cfg_pkg::btb_data_bits-1:0]  btb_rdata1,
  output logic                                    bht_wen,
  output logic [btac_cfg_pkg::bht_index_bits-1:0] bht_waddr,
  output btac_pred_pkg::counter_state_t           bht_wdata,
  output logic [btac_cfg_pkg::bht_index_bits-1:0] bht_raddr0,
  output logic [btac_cfg_pkg::bht_index_bits-1:0] bht_raddr1,
  input  wire  btac_pred_pkg::counter_state_t     bht_rdata0,
  input  wire  btac_pred_pkg::counter_state_t     bht_rdata1,
  input  wire  btac_pred_pkg::resolve_kind_t      kind0,
  input  wire  btac_pred_pkg::resolve_kind_t      kind1,
  input  wire  [31:0]                             fix_addr0,
  input  wire  [31:0]                             fix_addr1,
  input  wire  [31:0]                             store_target0,
  input  wire  [31:0]                             store_target1,
  input  wire  btac_pred_pkg::counter_state_t     next_counter0,
  input  wire  btac_pred_pkg::counter_state_t     next_counter1
);

  logic [31:0] lookup_pc0;
  logic [31:0] lookup_pc1;
  logic [31:0] held_pc0;
  logic [31:0] held_pc1;
  logic        tag_hit0;
  logic        tag_hit1;
  logic        live0;
  logic        live1;
  logic        miss0;
  logic        miss1;

  // a clear freezes the lookup so the same entries are read again.
  assign lookup_pc0 = clear ? held_pc0 : fetch_pc0;
  assign lookup_pc1 = clear ? held_pc1 : fetch_pc1;

  assign btb_raddr0 = lookup_pc0[btac_cfg_pkg::btb_index_bits:1];
  assign btb_raddr1 = lookup_pc1[btac_cfg_pkg::btb_index_bits:1];
  assign bht_raddr0 = lookup_pc0[btac_cfg_pkg::bht_index_bits:1];
  assign bht_raddr1 = lookup_pc1[btac_cfg_pkg::bht_index_bits:1];

  always_ff @(posedge clock) begin
    held_pc0 <= lookup_pc0;
    held_pc1 <= lookup_pc1;
  end

  assign tag_hit0 = btb_rdata0[btac_cfg_pkg::btb_data_bits-1 -: btac_cfg_pkg::btb_tag_bits] ==
                    held_pc0[31:btac_cfg_pkg::btb_index_bits+1];
  assign tag_hit1 = btb_rdata1[btac_cfg_pkg::btb_data_bits-1 -: btac_cfg_pkg::btb_tag_bits] ==
                    held_pc1[31:btac_cfg_pkg::btb_index_bits+1];

  always_comb begin
    pred_taken0 = 1'b0;
    pred_taken1 = 1'b0;
    pred_target0 = '0;
    pred_target1 = '0;
    pred_counter0 = btac_pred_pkg::strong_not_taken;
    pred_counter1 = btac_pred_pkg::strong_not_taken;
    if (!stall && !clear) begin
      pred_taken0 = bht_rdata0[1] && tag_hit0;
      pred_taken1 = bht_rdata1[1] && tag_hit1;
      pred_target0 = btb_rdata0[31:0];
      pred_target1 = btb_rdata1[31:0];
      pred_counter0 = bht_rdata0;
      pred_counter1 = bht_rdata1;
    end
  end

  // slot 0 owns the single write port whenever it has an event.
  assign live0 = !clear && (kind0 != btac_pred_pkg::resolve_idle);
  assign live1 = !clear && (kind1 != btac_pred_pkg::resolve_idle);
  assign miss0 = !clear && (kind0 == btac_pred_pkg::resolve_miss);
  assign miss1 = !clear && (kind1 == btac_pred_pkg::resolve_miss);

  assign btb_wen = live0 || live1;
  assign bht_wen = live0 || live1;

  always_comb begin
    btb_waddr = upd_pc1[btac_cfg_pkg::btb_index_bits:1];
    btb_wdata = {upd_pc1[31:btac_cfg_pkg::btb_index_bits+1], store_target1};
    bht_waddr = upd_pc1[btac_cfg_pkg::bht_index_bits:1];
    bht_wdata = next_counter1;
    if (live0) begin
      btb_waddr = upd_pc0[btac_cfg_pkg::btb_index_bits:1];
      btb_wdata = {upd_pc0[31:btac_cfg_pkg::btb_index_bits+1], store_target0};
      bht_waddr = upd_pc0[btac_cfg_pkg::bht_index_bits:1];
      bht_wdata = next_counter0;
    end
  end

  assign redirect_hazard = miss0; // lets fetch drop the younger slot in the same cycle.

  always_ff @(posedge clock) begin
    if (!reset) begin
      redirect_miss <= 1'b0;
    end else begin
      redirect_miss <= miss0 || miss1;
    end
  end

  always_ff @(posedge clock) begin
    redirect_addr <= miss0 ? fix_addr0 : fix_addr1;
  end

  assert property (@(posedge clock) clear |-> !btb_wen && !bht_wen)
    else $error("btac_ctrl: table write while clear is high");

  assert property (@(posedge clock) !reset |=> !redirect_miss)
    else $error("btac_ctrl: redirect_miss set right after reset");

  // both tables must stay on the same entry.
  assert property (@(posedge clock) btb_wen == bht_wen)
    else $error("btac_ctrl: target buffer and history table writes differ");

endmodule

`default_nettype wire

// File: hw/btac_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module btac_resolve (
  input  wire  [31:0]                         upd_npc0,
  input  wire  [31:0]                         upd_addr0,
  input  wire  btac_pred_pkg::outcome_t       upd_outcome0,
  input  wire                                 upd_pred_taken0,
  input  wire  [31:0]                         upd_pred_target0,
  input  wire  btac_pred_pkg::counter_state_t upd_pred_counter0,
  input  wire  [31:0]                         upd_npc1,
  input  wire  [31:0]                         upd_addr1,
  input  wire  btac_pred_pkg::outcome_t       upd_outcome1,
  input  wire                                 upd_pred_taken1,
  input  wire  [31:0]                         upd_pred_target1,
  input  wire  btac_pred_pkg::counter_state_t upd_pred_counter1,
  output btac_pred_pkg::resolve_kind_t        kind0,
  output btac_pred_pkg::resolve_kind_t        kind1,
  output logic [31:0]                         fix_addr0,
  output logic [31:0]                         fix_addr1,
  output logic [31:0]                         store_target0,
  output logic [31:0]                         store_target1,
  output btac_pred_pkg::counter_state_t       next_counter0,
  output btac_pred_pkg::counter_state_t       next_counter1
);

  function automatic logic actual_taken(input btac_pred_pkg::outcome_t outcome);
    return (outcome == btac_pred_pkg::outcome_taken) || (outcome == btac_pred_pkg::outcome_jump);
  endfunction

  function automatic btac_pred_pkg::resolve_kind_t slot_kind(
    input logic                    pred_taken,
    input btac_pred_pkg::outcome_t outcome,
    input logic [31:0]             addr,
    input logic [31:0]             pred_target
  );
    logic taken;
    taken = actual_taken(outcome);
    if (pred_taken && taken && (addr == pred_target)) begin
      return btac_pred_pkg::resolve_hit;
    end
    if (pred_taken != taken) begin
      return btac_pred_pkg::resolve_miss; // direction was wrong either way.
    end
    if (pred_taken) begin
      return btac_pred_pkg::resolve_miss; // taken as predicted but to another target.
    end
    return btac_pred_pkg::resolve_idle;
  endfunction

  // address the front end restarts from, and the target written to the buffer.
  function automatic logic [31:0] slot_fix(
    input logic                    pred_taken,
    input btac_pred_pkg::outcome_t outcome,
    input logic [31:0]             npc,
    input logic [31:0]             addr
  );
    if (!pred_taken && !actual_taken(outcome)) begin
      return '0;
    end
    return (pred_taken && !actual_taken(outcome)) ? npc : addr;
  endfunction

  function automatic logic [31:0] slot_store(
    input logic                    pred_taken,
    input btac_pred_pkg::outcome_t outcome,
    input logic [31:0]             npc,
    input logic [31:0]             addr
  );
    if (pred_taken && outcome == btac_pred_pkg::outcome_none) begin
      return npc; // not a branch at all, so the entry falls through.
    end
    return (pred_taken || actual_taken(outcome)) ? addr : '0;
  endfunction

  function automatic btac_pred_pkg::counter_state_t step(
    input btac_pred_pkg::counter_state_t counter,
    input btac_pred_pkg::outcome_t       outcome
  );
    logic taken;
    taken = actual_taken(outcome);
    case (counter)
      btac_pred_pkg::strong_not_taken: begin
        return taken ? btac_pred_pkg::weak_not_taken : btac_pred_pkg::strong_not_taken;
      end
      btac_pred_pkg::weak_not_taken: begin
        return taken ? btac_pred_pkg::weak_taken : btac_pred_pkg::strong_not_taken;
      end
      btac_pred_pkg::weak_taken: begin
        return taken ? btac_pred_pkg::strong_taken : btac_pred_pkg::weak_not_taken;
      end
      default: begin
        return taken ? btac_pred_pkg::strong_taken : btac_pred_pkg::weak_taken;
      end
    endcase
  endfunction

  assign kind0 = slot_kind(upd_pred_taken0, upd_outcome0, upd_addr0, upd_pred_target0);
  assign kind1 = slot_kind(upd_pred_taken1, upd_outcome1, upd_addr1, upd_pred_target1);
  assign fix_addr0 = slot_fix(upd_pred_taken0, upd_outcome0, upd_npc0, upd_addr0);
  assign fix_addr1 = slot_fix(upd_pred_taken1, upd_outcome1, upd_npc1, upd_addr1);
  assign store_target0 = slot_store(upd_pred_taken0, upd_outcome0, upd_npc0, upd_addr0);
  assign store_target1 = slot_store(upd_pred_taken1, upd_outcome1, upd_npc1, upd_addr1);
  assign next_counter0 = step(upd_pred_counter0, upd_outcome0);
  assign next_counter1 = step(upd_pred_counter1, upd_outcome1);

endmodule

`default_nettype wire

// File: hw/bht_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bht_ram (
  input  wire                                    clock,
  input  wire                                    wen,
  input  wire  [btac_cfg_pkg::bht_index_bits-1:0] waddr,
  input  wire  btac_pred_pkg::counter_state_t     wdata,
  input  wire  [btac_cfg_pkg::bht_index_bits-1:0] raddr0,
  input  wire  [btac_cfg_pkg::bht_index_bits-1:0] raddr1,
  output btac_pred_pkg::counter_state_t           rdata0,
  output btac_pred_pkg::counter_state_t           rdata1
);

  btac_pred_pkg::counter_state_t mem [btac_cfg_pkg::bht_entries] =
    '{default: btac_pred_pkg::strong_not_taken};

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata0 <= mem[raddr0];
    rdata1 <= mem[raddr1];
  end

  // the write address comes from the update pc through the control block.
  assert property (@(posedge clock) wen |-> !$isunknown(waddr))
    else $error("bht_ram: write with unknown address");

endmodule

`default_nettype wire

// File: hw/btb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module btb_ram (
  input  wire                                    clock,
  input  wire                                    wen,
  input  wire  [btac_cfg_pkg::btb_index_bits-1:0] waddr,
  input  wire  [btac_cfg_pkg::btb_data_bits-1:0]  wdata,
  input  wire  [btac_cfg_pkg::btb_index_bits-1:0] raddr0,
  input  wire  [btac_cfg_pkg::btb_index_bits-1:0] raddr1,
  output logic [btac_cfg_pkg::btb_data_bits-1:0]  rdata0,
  output logic [btac_cfg_pkg::btb_data_bits-1:0]  rdata1
);

  // each word holds the pc tag above the 32-bit target.
  logic [btac_cfg_pkg::btb_data_bits-1:0] mem [btac_cfg_pkg::btb_entries] = '{default: '0};

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata0 <= mem[raddr0]; // a read of the entry being written sees the old word.
    rdata1 <= mem[raddr1];
  end

endmodule

`default_nettype wire

// File: hw/btac_pred_pkg.sv
`default_nettype none

package btac_pred_pkg;

  // two-bit saturating counter; the upper bit is the taken prediction.
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_state_t;

  // what the execute stage found for a resolved instruction.
  typedef enum logic [1:0] {
    outcome_none      = 2'b00, // not a control-flow instruction.
    outcome_not_taken = 2'b01, // conditional branch that fell through.
    outcome_taken     = 2'b10,
    outcome_jump      = 2'b11
  } outcome_t;

  // result of one update slot.
  typedef enum logic [1:0] {
    resolve_idle = 2'b00,
    resolve_hit  = 2'b01,
    resolve_miss = 2'b10
  } resolve_kind_t;

endpackage

`default_nettype wire

// File: hw/btac_cfg_pkg.sv
`default_nettype none

package btac_cfg_pkg;

  // target buffer geometry.
  localparam int btb_entries = 64;
  localparam int btb_index_bits = $clog2(btb_entries); // index taken from pc bits 6:1.
  localparam int btb_tag_bits = 32 - btb_index_bits - 1; // pc bits above the index.
  localparam int btb_data_bits = btb_tag_bits + 32; // tag sits above the target.

  // history table geometry.
  localparam int bht_entries = 256;
  localparam int bht_index_bits = $clog2(bht_entries); // index taken from pc bits 8:1.

endpackage

`default_nettype wire
